//--- design/mipsPkg.sv
package mipsPkg;

        localparam int wordBits = 32;

        // primary opcodes, instr[31:26]
        typedef enum logic [5:0] {
                opSpecial  = 6'b000000,
                opSpecial2 = 6'b011100,
                opJ        = 6'b000010,
                opBeq      = 6'b000100,
                opBlez     = 6'b000110,
                opBgtz     = 6'b000111,
                opAddi     = 6'b001000,
                opAddiu    = 6'b001001,
                opLb       = 6'b100000,
                opLw       = 6'b100011,
                opLbu      = 6'b100100,
                opSb       = 6'b101000,
                opSw       = 6'b101011
        } opcodeE;

        // SPECIAL function field
        typedef enum logic [5:0] {
                fnSll  = 6'h00,
                fnSrl  = 6'h02,
                fnAddu = 6'h21,
                fnSubu = 6'h23,
                fnAnd  = 6'h24,
                fnOr   = 6'h25,
                fnNor  = 6'h27,
                fnSlt  = 6'h2a,
                fnSltu = 6'h2b
        } functE;

        // SPECIAL2 codes overlap SPECIAL ones (CLO shares 0x21 with ADDU)
        typedef enum logic [5:0] {
                fnClz = 6'h20,
                fnClo = 6'h21
        } spec2FunctE;

        typedef enum logic [3:0] {
                aluAdd, aluSub, aluAnd, aluOr, aluNor, aluSlt, aluSltu,
                aluSll, aluSrl, aluClz, aluClo, aluPass
        } aluOpE;

        typedef enum logic {memByte, memWord} memSizeE;

        typedef enum logic [1:0] {brEq, brLez, brGtz} branchKindE;

endpackage

//--- design/programCounter.sv
`timescale 1ns/1ps

module programCounter import mipsPkg::*; (
        input  logic                Clk,
        input  logic                reset,
        input  logic                run,
        input  logic                branchTaken,
        input  logic                jump,
        input  logic [wordBits-1:0] branchOffset,   // already sign-extended, in words
        input  logic [25:0]         jumpIndex,
        output logic [wordBits-1:0] pc
);
        logic [wordBits-1:0] pcPlus4;
        logic [wordBits-1:0] branchTarget;
        logic [wordBits-1:0] jumpTarget;
        logic [wordBits-1:0] pcNext;

        assign pcPlus4      = pc + 32'd4;
        assign branchTarget = pcPlus4 + (branchOffset << 2);
        assign jumpTarget   = {pc[31:28], jumpIndex, 2'b00};

        // no delay slot, redirect takes effect on the next fetch
        always_comb begin
                if (jump)
                        pcNext = jumpTarget;
                else if (branchTaken)
                        pcNext = branchTarget;
                else
                        pcNext = pcPlus4;
        end

        always_ff @(posedge Clk) begin
                if (reset)
                        pc <= '0;
                else if (run)
                        pc <= pcNext;
        end

        pcAligned: assert property (@(posedge Clk) disable iff (reset) pc[1:0] == 2'b00)
                else $error("pc lost word alignment: %h", pc);

endmodule

//--- design/instrMem.sv
`timescale 1ns/1ps

module instrMem #(
        parameter int progAddrBits = 9
) (
        input  logic                    Clk,
        input  logic                    progWrEn,
        input  logic [progAddrBits-1:0] progAddr,
        input  logic [31:0]             progData,
        input  logic [31:0]             pc,
        output logic [31:0]             instruction
);
        logic [7:0] mem [2**progAddrBits];
        logic [progAddrBits-3:0] loadWord;
        logic [progAddrBits-3:0] fetchWord;

        assign loadWord  = progAddr[progAddrBits-1:2];
        assign fetchWord = pc[progAddrBits-1:2];   // upper pc bits wrap

        // load port writes one whole word, msb byte first
        always_ff @(posedge Clk) begin
                if (progWrEn) begin
                        mem[{loadWord, 2'd0}] <= progData[31:24];
                        mem[{loadWord, 2'd1}] <= progData[23:16];
                        mem[{loadWord, 2'd2}] <= progData[15:8];
                        mem[{loadWord, 2'd3}] <= progData[7:0];
                end
        end

        assign instruction = {mem[{fetchWord, 2'd0}], mem[{fetchWord, 2'd1}],
                              mem[{fetchWord, 2'd2}], mem[{fetchWord, 2'd3}]};

endmodule

//--- design/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import mipsPkg::*; (
        input  logic [5:0]  opcode,
        input  logic [5:0]  funct,
        output logic        regDst,     // 1 selects rd, 0 selects rt
        output logic        regWrite,
        output logic        aluSrc,     // 1 selects the immediate
        output logic        signExt,
        output logic        memRead,
        output logic        memWrite,
        output memSizeE     memSize,
        output logic        loadUnsigned,
        output logic        memToReg,
        output logic        jump,
        output logic        branch,
        output branchKindE  branchKind,
        output aluOpE       aluOp
);
        always_comb begin
                // defaults are a no-op, unknown codes keep them
                regDst       = 1'b0;
                regWrite     = 1'b0;
                aluSrc       = 1'b0;
                signExt      = 1'b0;
                memRead      = 1'b0;
                memWrite     = 1'b0;
                memSize      = memWord;
                loadUnsigned = 1'b0;
                memToReg     = 1'b0;
                jump         = 1'b0;
                branch       = 1'b0;
                branchKind   = brEq;
                aluOp        = aluPass;

                case (opcodeE'(opcode))
                        opSpecial: begin
                                regDst   = 1'b1;
                                regWrite = 1'b1;
                                case (functE'(funct))
                                        fnAddu:  aluOp = aluAdd;
                                        fnSubu:  aluOp = aluSub;
                                        fnAnd:   aluOp = aluAnd;
                                        fnOr:    aluOp = aluOr;
                                        fnNor:   aluOp = aluNor;
                                        fnSlt:   aluOp = aluSlt;
                                        fnSltu:  aluOp = aluSltu;
                                        fnSll:   aluOp = aluSll;
                                        fnSrl:   aluOp = aluSrl;
                                        default: regWrite = 1'b0;
                                endcase
                        end
                        opSpecial2: begin
                                regDst   = 1'b1;
                                regWrite = 1'b1;
                                case (spec2FunctE'(funct))
                                        fnClz:   aluOp = aluClz;
                                        fnClo:   aluOp = aluClo;
                                        default: regWrite = 1'b0;
                                endcase
                        end
                        opAddi, opAddiu: begin   // neither one traps
                                regWrite = 1'b1;
                                aluSrc   = 1'b1;
                                signExt  = 1'b1;
                                aluOp    = aluAdd;
                        end
                        opLb, opLbu, opLw: begin
                                regWrite     = 1'b1;
                                aluSrc       = 1'b1;
                                signExt      = 1'b1;
                                memRead      = 1'b1;
                                memToReg     = 1'b1;
                                aluOp        = aluAdd;
                                memSize      = (opcode == opLw) ? memWord : memByte;
                                loadUnsigned = (opcode == opLbu);
                        end
                        opSb, opSw: begin
                                aluSrc   = 1'b1;
                                signExt  = 1'b1;
                                memWrite = 1'b1;
                                aluOp    = aluAdd;
                                memSize  = (opcode == opSw) ? memWord : memByte;
                        end
                        opBeq: branch = 1'b1;
                        opBlez: begin
                                branch     = 1'b1;
                                branchKind = brLez;
                        end
                        opBgtz: begin
                                branch     = 1'b1;
                                branchKind = brGtz;
                        end
                        opJ: jump = 1'b1;
                        default: ;
                endcase
        end

        always_comb begin
                noLoadStore: assert (!(memRead && memWrite))
                        else $error("load and store decoded together, opcode %b", opcode);
        end

endmodule

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
        input  logic                Clk,
        input  logic                reset,
        input  logic [4:0]          readAddrA,
        input  logic [4:0]          readAddrB,
        input  logic                writeEn,
        input  logic [4:0]          writeAddr,
        input  logic [wordBits-1:0] writeData,
        output logic [wordBits-1:0] readDataA,
        output logic [wordBits-1:0] readDataB
);
        logic [wordBits-1:0] regs [32];

        assign readDataA = regs[readAddrA];
        assign readDataB = regs[readAddrB];

        // $zero is cleared by reset and never written after
        always_ff @(posedge Clk) begin
                if (reset)
                        regs <= '{default: '0};
                else if (writeEn && writeAddr != 5'd0)
                        regs[writeAddr] <= writeData;
        end

        zeroReadsZero: assert property (@(posedge Clk) disable iff (reset)
                (readAddrA == 5'd0) |-> (readDataA == '0))
                else $error("register zero read back %h", readDataA);

endmodule

//--- design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import mipsPkg::*; (
        input  logic [wordBits-1:0] opA,
        input  logic [wordBits-1:0] opB,
        input  logic [4:0]          shamt,
        input  aluOpE               aluOp,
        input  logic                branch,
        input  branchKindE          branchKind,
        output logic [wordBits-1:0] result,
        output logic                branchTaken
);
        logic condMet;

        // run of leading bits equal to match, 32 when the whole word matches
        function automatic logic [5:0] leadCount(input logic [wordBits-1:0] value,
                                                 input logic match);
                logic [5:0] count;
                logic done;
                count = '0;
                done  = 1'b0;
                for (int i = wordBits - 1; i >= 0; i--) begin
                        if (!done && value[i] == match)
                                count = count + 6'd1;
                        else
                                done = 1'b1;
                end
                return count;
        endfunction

        always_comb begin
                case (aluOp)
                        aluAdd:  result = opA + opB;
                        aluSub:  result = opA - opB;
                        aluAnd:  result = opA & opB;
                        aluOr:   result = opA | opB;
                        aluNor:  result = ~(opA | opB);
                        aluSlt:  result = {{(wordBits-1){1'b0}}, $signed(opA) < $signed(opB)};
                        aluSltu: result = {{(wordBits-1){1'b0}}, opA < opB};
                        aluSll:  result = opB << shamt;   // shifts act on rt
                        aluSrl:  result = opB >> shamt;
                        aluClz:  result = {{(wordBits-6){1'b0}}, leadCount(opA, 1'b0)};
                        aluClo:  result = {{(wordBits-6){1'b0}}, leadCount(opA, 1'b1)};
                        default: result = opB;            // aluPass
                endcase
        end

        // BLEZ and BGTZ look at rs only
        always_comb begin
                case (branchKind)
                        brEq:    condMet = (opA == opB);
                        brLez:   condMet = ($signed(opA) <= 0);
                        brGtz:   condMet = ($signed(opA) > 0);
                        default: condMet = 1'b0;
                endcase
        end

        assign branchTaken = branch && condMet;

endmodule

//--- design/dataMem.sv
`timescale 1ns/1ps

module dataMem import mipsPkg::*; #(
        parameter int dataAddrBits = 9
) (
        input  logic                Clk,
        input  logic                reset,
        input  logic [wordBits-1:0] addr,
        input  logic [wordBits-1:0] writeData,
        input  logic                memWrite,
        input  logic                memRead,
        input  memSizeE             memSize,
        input  logic                loadUnsigned,
        output logic [wordBits-1:0] readData
);
        logic [7:0] mem [2**dataAddrBits];
        logic [dataAddrBits-1:0] byteAddr;
        logic [dataAddrBits-3:0] wordBase;   // word holding byteAddr
        logic [7:0] loadByte;

        assign byteAddr = addr[dataAddrBits-1:0];
        assign wordBase = byteAddr[dataAddrBits-1:2];
        assign loadByte = mem[byteAddr];

        // big-endian, msb at the lowest address
        always_ff @(posedge Clk) begin
                if (reset) begin
                        mem <= '{default: '0};
                end else if (memWrite) begin
                        if (memSize == memWord) begin
                                mem[{wordBase, 2'd0}] <= writeData[31:24];
                                mem[{wordBase, 2'd1}] <= writeData[23:16];
                                mem[{wordBase, 2'd2}] <= writeData[15:8];
                                mem[{wordBase, 2'd3}] <= writeData[7:0];
                        end else begin
                                mem[byteAddr] <= writeData[7:0];   // SB keeps the low byte
                        end
                end
        end

        always_comb begin
                if (!memRead)
                        readData = '0;
                else if (memSize == memWord)
                        readData = {mem[{wordBase, 2'd0}], mem[{wordBase, 2'd1}],
                                    mem[{wordBase, 2'd2}], mem[{wordBase, 2'd3}]};
                else if (loadUnsigned)
                        readData = {{(wordBits-8){1'b0}}, loadByte};
                else
                        readData = {{(wordBits-8){loadByte[7]}}, loadByte};
        end

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
        parameter int progAddrBits = 9,
        parameter int dataAddrBits = 9
) (
        input  logic                    Clk,
        input  logic                    reset,
        input  logic                    run,
        input  logic                    progWrEn,
        input  logic [progAddrBits-1:0] progAddr,
        input  logic [wordBits-1:0]     progData,
        output logic                    retireValid,
        output logic [wordBits-1:0]     retirePc,
        output logic                    regWrEn,
        output logic [4:0]              regWrAddr,
        output logic [wordBits-1:0]     regWrData,
        output logic                    memWrEn,
        output logic [wordBits-1:0]     memWrAddr,
        output logic [wordBits-1:0]     memWrData
);
        logic [wordBits-1:0] pc, instruction;
        logic [wordBits-1:0] rsData, rtData, immExt, branchOffset, aluB, aluResult, loadData;
        logic regDst, regWrite, aluSrc, signExt, memRead, memWrite;
        logic loadUnsigned, memToReg, jump, branch, branchTaken;
        memSizeE memSize;
        branchKindE branchKind;
        aluOpE aluOp;

        programCounter pc0 (
                .Clk(Clk), .reset(reset), .run(run),
                .branchTaken(branchTaken), .jump(jump),
                .branchOffset(branchOffset), .jumpIndex(instruction[25:0]),
                .pc(pc)
        );

        instrMem #(.progAddrBits(progAddrBits)) imem0 (
                .Clk(Clk), .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
                .pc(pc), .instruction(instruction)
        );

        controlDecoder dec0 (
                .opcode(instruction[31:26]), .funct(instruction[5:0]),
                .regDst(regDst), .regWrite(regWrite), .aluSrc(aluSrc), .signExt(signExt),
                .memRead(memRead), .memWrite(memWrite), .memSize(memSize),
                .loadUnsigned(loadUnsigned), .memToReg(memToReg), .jump(jump),
                .branch(branch), .branchKind(branchKind), .aluOp(aluOp)
        );

        regFile rf0 (
                .Clk(Clk), .reset(reset),
                .readAddrA(instruction[25:21]), .readAddrB(instruction[20:16]),
                .writeEn(regWrEn), .writeAddr(regWrAddr), .writeData(regWrData),
                .readDataA(rsData), .readDataB(rtData)
        );

        // operand select
        assign branchOffset = {{16{instruction[15]}}, instruction[15:0]};
        assign immExt = signExt ? branchOffset : {16'b0, instruction[15:0]};
        assign aluB   = aluSrc ? immExt : rtData;

        aluUnit alu0 (
                .opA(rsData), .opB(aluB), .shamt(instruction[10:6]), .aluOp(aluOp),
                .branch(branch), .branchKind(branchKind),
                .result(aluResult), .branchTaken(branchTaken)
        );

        dataMem #(.dataAddrBits(dataAddrBits)) dmem0 (
                .Clk(Clk), .reset(reset), .addr(aluResult), .writeData(rtData),
                .memWrite(memWrEn), .memRead(memRead), .memSize(memSize),
                .loadUnsigned(loadUnsigned), .readData(loadData)
        );

        // writeback, every state change waits for run
        assign regWrEn   = regWrite && run;
        assign regWrAddr = regDst ? instruction[15:11] : instruction[20:16];
        assign regWrData = memToReg ? loadData : aluResult;
        assign memWrEn   = memWrite && run;

        // retire trace mirrors this cycle's commit
        assign retireValid = run;
        assign retirePc    = pc;
        assign memWrAddr   = aluResult;
        assign memWrData   = (memSize == memByte) ? {24'b0, rtData[7:0]} : rtData;

endmodule

//--- sim/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
        localparam int progAddrBits = 9;
        localparam int dataAddrBits = 9;
        localparam int depth        = 512;   // words of testdata
        localparam int resetCycles  = 16;

        logic                    Clk;
        logic                    reset;
        logic                    run;
        logic                    progWrEn;
        logic [progAddrBits-1:0] progAddr;
        logic [31:0]             progData;
        logic                    retireValid;
        logic [31:0]             retirePc;
        logic                    regWrEn;
        logic [4:0]              regWrAddr;
        logic [31:0]             regWrData;
        logic                    memWrEn;
        logic [31:0]             memWrAddr;
        logic [31:0]             memWrData;

        logic [31:0] tdata [0:depth-1];
        int numProg, recStart, numRec;
        int errorCount, checkCount, testsRun, testsFailed, testStartErrors;
        int cycleCount, cycleLimit;

        mipsCore #(.progAddrBits(progAddrBits), .dataAddrBits(dataAddrBits)) dut0 (
                .Clk(Clk), .reset(reset), .run(run),
                .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
                .retireValid(retireValid), .retirePc(retirePc),
                .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
                .memWrEn(memWrEn), .memWrAddr(memWrAddr), .memWrData(memWrData)
        );

        always #10 Clk = ~Clk;

        always @(posedge Clk) begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= cycleLimit) begin
                        $display("Timeout: trace not finished after %0d cycles", cycleCount);
                        $display("SOME TESTS FAILED");
                        $finish;
                end
        end

        task automatic checkValue(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
                checkCount++;
                if (got !== expected) begin
                        errorCount++;
                        $display("Fail at %0t: %s is %h, expected %h", $time, what, got,
                                 expected);
                end
        endtask

        task automatic checkQuiet(input string phase);
                checkValue({phase, " retireValid"}, {31'b0, retireValid}, 32'd0);
                checkValue({phase, " regWrEn"}, {31'b0, regWrEn}, 32'd0);
                checkValue({phase, " memWrEn"}, {31'b0, memWrEn}, 32'd0);
        endtask

        function automatic string testName(input int id);
                string name;
                case (id)
                        1:       name = "quiet outputs in reset and load";
                        2:       name = "arithmetic, logic and shifts";
                        3:       name = "leading ones and zeros count";
                        4:       name = "loads and stores";
                        5:       name = "branches and jumps";
                        6:       name = "idle after run drops";
                        default: name = "unnamed";
                endcase
                return name;
        endfunction

        task automatic finishTest(input int id);
                int bad;
                bad = errorCount - testStartErrors;
                testsRun++;
                if (bad == 0) begin
                        $display("test %0d, %s: pass", id, testName(id));
                end else begin
                        testsFailed++;
                        $display("test %0d, %s: %0d mismatches", id, testName(id), bad);
                end
                testStartErrors = errorCount;
        endtask

        // record columns: test pc rw ra rd mw ma md
        function automatic logic [31:0] recordField(input int r, input int k);
                return tdata[recStart + r * 8 + k];
        endfunction

        task automatic checkRecord(input int r);
                string tag;
                tag = $sformatf("record %0d", r);
                checkValue({tag, " retirePc"}, retirePc, recordField(r, 1));
                checkValue({tag, " regWrEn"}, {31'b0, regWrEn}, recordField(r, 2));
                if (recordField(r, 2) == 32'd1) begin
                        checkValue({tag, " regWrAddr"}, {27'b0, regWrAddr}, recordField(r, 3));
                        checkValue({tag, " regWrData"}, regWrData, recordField(r, 4));
                end
                checkValue({tag, " memWrEn"}, {31'b0, memWrEn}, recordField(r, 5));
                if (recordField(r, 5) == 32'd1) begin
                        checkValue({tag, " memWrAddr"}, memWrAddr, recordField(r, 6));
                        checkValue({tag, " memWrData"}, memWrData, recordField(r, 7));
                end
        endtask

        // one cycle with run low, the pending instruction must not commit
        task automatic pauseRun();
                @(posedge Clk);
                run <= 1'b0;
                @(negedge Clk);
                checkQuiet("paused");
                @(posedge Clk);
                run <= 1'b1;
        endtask

        task automatic runTests();
                int cur;
                logic paused;
                paused = 1'b0;
                repeat (resetCycles - 1) begin
                        @(negedge Clk);
                        checkQuiet("reset");
                end
                @(posedge Clk);
                reset <= 1'b0;   // 16th edge
                for (int i = 0; i < numProg; i++) begin
                        @(posedge Clk);
                        progWrEn <= 1'b1;
                        progAddr <= progAddrBits'(i * 4);
                        progData <= tdata[i];
                        @(negedge Clk);
                        checkQuiet("load");
                end
                @(posedge Clk);
                progWrEn <= 1'b0;
                run      <= 1'b1;
                finishTest(1);

                cur = recordField(0, 0);
                for (int r = 0; r < numRec; r++) begin
                        if (recordField(r, 0) != cur) begin
                                finishTest(cur);
                                cur = recordField(r, 0);
                        end
                        // stall once with the first store waiting at the pc
                        if (!paused && r > 0 && recordField(r, 5) == 32'd1) begin
                                pauseRun();
                                paused = 1'b1;
                        end
                        @(negedge Clk);
                        while (!retireValid)
                                @(negedge Clk);
                        checkRecord(r);
                end
                @(posedge Clk);   // last record commits here
                run <= 1'b0;
                finishTest(cur);

                // no retire once run is low
                @(negedge Clk);
                checkQuiet("stopped");
                finishTest(6);

                $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                         testsRun, testsFailed, checkCount, errorCount);
                if (errorCount == 0 && testsFailed == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        endtask

        initial begin
                int sep;
                $timeformat(-9, 0, " ns", 0);
                Clk      = 1'b0;
                reset    = 1'b1;
                run      = 1'b0;
                progWrEn = 1'b0;
                progAddr = '0;
                progData = '0;
                $readmemh("sim/mipsTestdata.txt", tdata);
                sep = 0;
                while (sep < depth && tdata[sep] !== 32'hffffffff)
                        sep++;
                numProg  = sep;
                recStart = sep + 1;
                numRec   = 0;
                while (recStart + numRec * 8 < depth &&
                       tdata[recStart + numRec * 8] !== 32'hffffffff)
                        numRec++;
                cycleLimit = 2 * numRec + numProg + resetCycles;
                if (sep >= depth || recStart + numRec * 8 >= depth || numRec == 0 ||
                    numProg > 2 ** (progAddrBits - 2)) begin
                        $display("Testdata file is missing, too large or lacks its end markers");
                        $display("SOME TESTS FAILED");
                        $finish;
                end else begin
                        runTests();
                end
        end

endmodule

//--- sim/mipsTestdata.txt
// program words, four per line, ended by ffffffff
// then records: test pc regWrEn regWrAddr regWrData memWrEn memWrAddr memWrData
2401fffb 20020007 00221821 00222023
00222824 00223025 00223827 0022402a
0022482b 00025100 00015f02 24000009
00026021 70cd6821 70ee7020 702f7821
71708020 ac010010 8c110010 a0010020
80120020 90130020 24140002 2694ffff
1e80fffe 12800001 24150001 10400001
18200001 24150002 08000020 24150003
24160055 08000021
ffffffff
2 00 1 01 fffffffb 0 0 0
2 04 1 02 00000007 0 0 0
2 08 1 03 00000002 0 0 0
2 0c 1 04 fffffff4 0 0 0
2 10 1 05 00000003 0 0 0
2 14 1 06 ffffffff 0 0 0
2 18 1 07 00000000 0 0 0
2 1c 1 08 00000001 0 0 0
2 20 1 09 00000000 0 0 0
2 24 1 0a 00000070 0 0 0
2 28 1 0b 0000000f 0 0 0
2 2c 1 00 00000009 0 0 0
2 30 1 0c 00000007 0 0 0
3 34 1 0d 00000020 0 0 0
3 38 1 0e 00000020 0 0 0
3 3c 1 0f 0000001d 0 0 0
3 40 1 10 0000001c 0 0 0
4 44 0 00 00000000 1 10 fffffffb
4 48 1 11 fffffffb 0 0 0
4 4c 0 00 00000000 1 20 000000fb
4 50 1 12 fffffffb 0 0 0
4 54 1 13 000000fb 0 0 0
5 58 1 14 00000002 0 0 0
5 5c 1 14 00000001 0 0 0
5 60 0 00 00000000 0 0 0
5 5c 1 14 00000000 0 0 0
5 60 0 00 00000000 0 0 0
5 64 0 00 00000000 0 0 0
5 6c 0 00 00000000 0 0 0
5 70 0 00 00000000 0 0 0
5 78 0 00 00000000 0 0 0
5 80 1 16 00000055 0 0 0
5 84 0 00 00000000 0 0 0
ffffffff

//--- build.f
design/mipsPkg.sv
design/programCounter.sv
design/instrMem.sv
design/controlDecoder.sv
design/regFile.sv
design/aluUnit.sv
design/dataMem.sv
design/mipsCore.sv
sim/mipsCoreTb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module mipsCoreTb -f build.f -o simv \
        && ./obj_dir/simv > sim.log 2>&1 \
        || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
        || echo "simulation passed"
